// ==== spi_pkg.sv ====
package spi_pkg;

  localparam int CMD_BITS  = 12;
  localparam int DATA_BITS = 8;
  localparam int ADDR_BITS = 3;

  // Command word: [11] write flag, [10:8] register address, [7:0] write data.
  typedef logic [CMD_BITS-1:0]  spi_cmd_t;
  typedef logic [DATA_BITS-1:0] spi_data_t;
  typedef logic [ADDR_BITS-1:0] spi_addr_t;

  typedef logic [3:0] spi_bit_cnt_t;
  typedef logic [7:0] spi_gap_cnt_t;
  typedef logic [2:0] spi_div_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    W_SHIFT,
    W_DONE,
    R_ADDR,
    R_GAP,
    R_SHIFT,
    R_DONE
  } spi_state_e;

  // clk cycles per sclk half period.
  localparam spi_div_cnt_t SCLK_HALF = 3'd4;

  localparam spi_bit_cnt_t WRITE_BITS     = 4'd12;
  localparam spi_bit_cnt_t READ_ADDR_BITS = 4'd4;
  localparam spi_bit_cnt_t READ_DATA_BITS = 4'd8;

  // cs high time between the address and data phases of a read.
  localparam spi_gap_cnt_t READ_GAP = 8'd100;

endpackage

// ==== spi_sclk_gen.sv ====
module spi_sclk_gen
  import spi_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  output logic sclk,
  output logic rise,
  output logic fall
);

  spi_div_cnt_t div_cnt_q;
  logic         started_q;
  logic         tick;

  assign tick = sclk_en && (div_cnt_q == SCLK_HALF - 3'd1);

  // The first tick of a frame is a fall with sclk already low.
  // It puts bit 0 on mosi half a period before the first rising edge.
  assign fall = tick && (!started_q || sclk);
  assign rise = tick && started_q && !sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt_q <= '0;
      started_q <= 1'b0;
      sclk      <= 1'b0;
    end
    else if (!sclk_en)
    begin
      div_cnt_q <= '0;
      started_q <= 1'b0;
      sclk      <= 1'b0;
    end
    else if (tick)
    begin
      div_cnt_q <= '0;
      started_q <= 1'b1;
      if (started_q)
      begin
        sclk <= ~sclk;
      end
    end
    else
    begin
      div_cnt_q <= div_cnt_q + 3'd1;
    end
  end

  // Each strobe fixes the level sclk takes next, so rise and fall never coincide.
  a_rise_sets_sclk : assert property (
    @(posedge clk) disable iff (!rst_n)
    rise |=> sclk
  );

  a_fall_clears_sclk : assert property (
    @(posedge clk) disable iff (!rst_n)
    fall |=> !sclk
  );

endmodule

// ==== spi_shifter.sv ====
module spi_shifter
  import spi_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         load,
  input  spi_cmd_t     load_word,
  input  spi_bit_cnt_t load_len,
  input  logic         rise,
  input  logic         fall,
  input  logic         miso,
  output logic         mosi,
  output spi_data_t    read_data
);

  spi_cmd_t     tx_q;
  spi_data_t    rx_q;
  spi_bit_cnt_t tx_left_q;

  // Meaningful bits arrive right-aligned; move them to the MSB end.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      tx_q <= load_word << (CMD_BITS - int'(load_len));
    end
    else if (fall)
    begin
      tx_q <= {tx_q[CMD_BITS-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mosi <= 1'b0;
    end
    else if (fall)
    begin
      mosi <= tx_q[CMD_BITS-1];
    end
  end

  // Outgoing bits not yet sampled by the device.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_left_q <= '0;
    end
    else if (load)
    begin
      tx_left_q <= load_len;
    end
    else if (rise && (tx_left_q != '0))
    begin
      tx_left_q <= tx_left_q - 4'd1;
    end
  end

  // Receive only once the transmit side is drained, so write frames
  // leave the last read byte untouched.
  always_ff @(posedge clk)
  begin
    if (rise && (tx_left_q == '0))
    begin
      rx_q <= {rx_q[DATA_BITS-2:0], miso};
    end
  end

  assign read_data = rx_q;

endmodule

// ==== spi_cmd_ctrl.sv ====
module spi_cmd_ctrl
  import spi_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  spi_cmd_t     cmd_in,
  input  logic         cmd_vld,
  output logic         cmd_rdy,
  input  logic         rise,
  input  logic         fall,
  output logic         sclk_en,
  output logic         cs,
  output logic         load,
  output spi_cmd_t     load_word,
  output spi_bit_cnt_t load_len,
  output logic         read_vld
);

  spi_state_e   state_q;
  spi_state_e   state_d;
  spi_cmd_t     cmd_q;
  spi_bit_cnt_t bit_cnt_q;
  spi_gap_cnt_t gap_cnt_q;
  logic         read_vld_q;
  logic         shifting;
  logic         is_write;

  assign is_write = cmd_q[CMD_BITS-1];
  assign shifting = (state_q == W_SHIFT) || (state_q == R_ADDR) || (state_q == R_SHIFT);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (cmd_vld)
        begin
          state_d = LOAD;
        end
      end
      LOAD:
      begin
        state_d = is_write ? W_SHIFT : R_ADDR;
      end
      // The fall after the last bit closes its period.
      W_SHIFT:
      begin
        if (fall && (bit_cnt_q == WRITE_BITS))
        begin
          state_d = W_DONE;
        end
      end
      W_DONE:
      begin
        state_d = IDLE;
      end
      R_ADDR:
      begin
        if (fall && (bit_cnt_q == READ_ADDR_BITS))
        begin
          state_d = R_GAP;
        end
      end
      R_GAP:
      begin
        if (gap_cnt_q == READ_GAP - 8'd1)
        begin
          state_d = R_SHIFT;
        end
      end
      R_SHIFT:
      begin
        if (rise && (bit_cnt_q == READ_DATA_BITS - 4'd1))
        begin
          state_d = R_DONE;
        end
      end
      R_DONE:
      begin
        state_d = IDLE;
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state_q == IDLE) && cmd_vld)
    begin
      cmd_q <= cmd_in;
    end
  end

  // Outgoing phases count falls, the incoming phase counts rises.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt_q <= '0;
    end
    else if (!shifting)
    begin
      bit_cnt_q <= '0;
    end
    else if ((state_q == R_SHIFT) ? rise : fall)
    begin
      bit_cnt_q <= bit_cnt_q + 4'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gap_cnt_q  <= '0;
      read_vld_q <= 1'b0;
    end
    else
    begin
      gap_cnt_q  <= (state_q == R_GAP) ? gap_cnt_q + 8'd1 : '0;
      read_vld_q <= (state_q == R_DONE);
    end
  end

  // The done states keep cs low one cycle past the last sclk edge.
  assign cs       = !(shifting || (state_q == W_DONE) || (state_q == R_DONE));
  assign cmd_rdy  = (state_q == IDLE);
  assign sclk_en  = shifting;
  assign load     = (state_q == LOAD);
  assign read_vld = read_vld_q;

  assign load_word = is_write ? cmd_q : spi_cmd_t'(cmd_q[CMD_BITS-1 -: READ_ADDR_BITS]);
  assign load_len  = is_write ? WRITE_BITS : READ_ADDR_BITS;

  // A frame ends with cs and cmd_rdy going high in the same cycle.
  a_rdy_rises_with_cs : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> $rose(cs)
  );

  a_read_vld_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |-> cs ##1 !read_vld
  );

endmodule

// ==== spi_cmd_top.sv ====
module spi_cmd_top
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  spi_cmd_t  cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  output spi_data_t read_data,
  output logic      read_vld,
  output logic      sclk,
  output logic      cs,
  output logic      mosi,
  input  logic      miso
);

  logic         sclk_en;
  logic         rise;
  logic         fall;
  logic         load;
  spi_cmd_t     load_word;
  spi_bit_cnt_t load_len;

  spi_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rise      (rise),
    .fall      (fall),
    .sclk_en   (sclk_en),
    .cs        (cs),
    .load      (load),
    .load_word (load_word),
    .load_len  (load_len),
    .read_vld  (read_vld)
  );

  spi_sclk_gen u_sclk_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .sclk_en (sclk_en),
    .sclk    (sclk),
    .rise    (rise),
    .fall    (fall)
  );

  spi_shifter u_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .load_word (load_word),
    .load_len  (load_len),
    .rise      (rise),
    .fall      (fall),
    .miso      (miso),
    .mosi      (mosi),
    .read_data (read_data)
  );

endmodule

// ==== spi_slave_model.sv ====
module spi_slave_model
  import spi_pkg::*;
(
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  timeunit 1ns;
  timeprecision 1ps;

  spi_data_t regs [8];
  spi_cmd_t  rx_sh;
  int        rx_bits;
  spi_data_t tx_sh;
  logic      read_pending;
  spi_addr_t read_addr;

  initial
  begin
    foreach (regs[i])
      regs[i] = '0;
    rx_sh        = '0;
    rx_bits      = 0;
    tx_sh        = '0;
    read_pending = 1'b0;
    read_addr    = '0;
    miso         = 1'b0;
  end

  // A data phase after an address frame presents the MSB before the first rising edge.
  always @(negedge cs)
  begin
    rx_bits = 0;
    tx_sh   = read_pending ? regs[read_addr] : '0;
    miso    = tx_sh[DATA_BITS-1];
  end

  always @(posedge sclk)
  begin
    if (!cs)
    begin
      rx_sh   = {rx_sh[CMD_BITS-2:0], mosi};
      rx_bits = rx_bits + 1;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs)
    begin
      tx_sh = {tx_sh[DATA_BITS-2:0], 1'b0};
      miso  = tx_sh[DATA_BITS-1];
    end
  end

  // Frame end decodes what was shifted in.
  always @(posedge cs)
  begin
    if ((rx_bits == int'(WRITE_BITS)) && rx_sh[CMD_BITS-1])
      regs[rx_sh[CMD_BITS-2 -: ADDR_BITS]] = rx_sh[DATA_BITS-1:0];
    read_pending = (rx_bits == int'(READ_ADDR_BITS)) && !rx_sh[ADDR_BITS];
    read_addr    = rx_sh[ADDR_BITS-1:0];
  end

endmodule

// ==== tb_spi_cmd_top.sv ====
module tb_spi_cmd_top
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic      clk;
  logic      rst_n;
  spi_cmd_t  cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  spi_data_t read_data;
  logic      read_vld;
  logic      sclk;
  logic      cs;
  logic      mosi;
  logic      miso;

  string       test_name [$];
  spi_cmd_t    test_cmd [$];
  spi_data_t   test_exp [$];
  string       pend_name [$];
  spi_data_t   pend_exp [$];
  spi_data_t   mirror [8];
  int          rdy_rises;
  int          read_pulses;
  int          num_reads;
  logic        rdy_prev;
  logic        tests_loaded;
  logic [31:0] rng_state;

  spi_cmd_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_vld  (read_vld),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso)
  );

  spi_slave_model u_slave (
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .miso (miso)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input spi_data_t expected, input spi_data_t actual);
    if (actual !== expected)
      abort_run($sformatf("error %s expected %02h actual %02h", name, expected, actual));
  endtask

  task automatic check_cmd_count(input string name, input int expected, input int actual);
    if (actual != expected)
      abort_run($sformatf("error %s expected %0d actual %0d", name, expected, actual));
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("error %s expected %b actual %b", name, expected, actual));
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic load_tests();
    int       fd;
    int       n;
    string    line;
    string    name;
    string    exp_str;
    spi_cmd_t cmd;
    fd = $fopen("spi_cmd_testdata.txt", "r");
    if (fd == 0)
      abort_run("could not open spi_cmd_testdata.txt");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if ((line.len() == 0) || (line.getc(0) == "#"))
        continue;
      n = $sscanf(line, "%s %h %s", name, cmd, exp_str);
      if (n == 3)
      begin
        test_name.push_back(name);
        test_cmd.push_back(cmd);
        test_exp.push_back((exp_str == "--") ? spi_data_t'(0) : spi_data_t'(exp_str.atohex()));
      end
    end
    $fclose(fd);
    if (test_cmd.size() == 0)
      abort_run("no tests found in spi_cmd_testdata.txt");
  endtask

  // The next command goes out while the previous frame is still running.
  task automatic issue_command(input int idx);
    spi_cmd_t  cmd;
    spi_addr_t addr;
    int        gap;
    cmd       = test_cmd[idx];
    addr      = cmd[CMD_BITS-2 -: ADDR_BITS];
    rng_state = next_random(rng_state);
    gap       = int'(rng_state % 32'd8);
    repeat (gap)
    begin
      @(posedge clk);
      #1;
    end
    if (cmd[CMD_BITS-1])
      mirror[addr] = cmd[DATA_BITS-1:0];
    else if (test_exp[idx] !== mirror[addr])
      abort_run($sformatf("test data for %s disagrees with the written register value",
                          test_name[idx]));
    else
    begin
      pend_name.push_back(test_name[idx]);
      pend_exp.push_back(test_exp[idx]);
      num_reads++;
    end
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (cs)
        check_level("sclk_idle", 1'b0, sclk);
      if (read_vld)
      begin
        read_pulses++;
        check_level("cs_at_read_vld", 1'b1, cs);
        if (pend_exp.size() == 0)
          abort_run("read_vld pulsed with no read command pending");
        else
          check_data(pend_name.pop_front(), pend_exp.pop_front(), read_data);
      end
      if (cmd_rdy && !rdy_prev)
        rdy_rises++;
      rdy_prev = cmd_rdy;
    end
  end

  initial
  begin
    int limit;
    wait (tests_loaded);
    limit = test_cmd.size() * (int'(WRITE_BITS) * 2 * int'(SCLK_HALF) + int'(READ_GAP)
            + int'(READ_DATA_BITS) * 2 * int'(SCLK_HALF) + 40);
    repeat (limit) @(posedge clk);
    abort_run($sformatf("watchdog expired after %0d clock cycles", limit));
  end

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    rng_state    = 32'h3ed3_3e50;
    rdy_prev     = 1'b1;
    rdy_rises    = 0;
    read_pulses  = 0;
    num_reads    = 0;
    tests_loaded = 1'b0;
    foreach (mirror[i])
      mirror[i] = '0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_level("reset_cmd_rdy", 1'b1, cmd_rdy);
    check_level("reset_cs", 1'b1, cs);
    check_level("reset_read_vld", 1'b0, read_vld);
    check_level("reset_mosi", 1'b0, mosi);
    @(posedge clk);
    #1;
    for (int i = 0; i < test_cmd.size(); i++)
      issue_command(i);
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    repeat (4) @(negedge clk);
    check_cmd_count("cmd_rdy_rises", test_cmd.size(), rdy_rises);
    check_cmd_count("read_vld_pulses", num_reads, read_pulses);
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== spi_cmd_testdata.txt ====
# Each line holds a test name, a 12-bit command in hex and the expected read byte in hex.
# Write commands carry -- in place of a read byte.
rd_unwritten_5 500 00
wr_a2 AA5 --
rd_a2 200 A5
rd_unwritten_7 700 00
wr_a2_again A3C --
rd_a2_again 200 3C
wr_all_0 8C1 --
wr_all_1 9E2 --
wr_all_2 A03 --
wr_all_3 BF4 --
wr_all_4 C5A --
wr_all_5 D96 --
wr_all_6 E7F --
wr_all_7 F80 --
rd_rev_7 700 80
rd_rev_6 600 7F
rd_rev_5 500 96
rd_rev_4 400 5A
rd_rev_3 300 F4
rd_rev_2 200 03
rd_rev_1 100 E2
rd_rev_0 000 C1
wr_a0_ff 8FF --
rd_a0_ff 0FF FF
rd_a1_again 1AB E2
wr_a6_zero E00 --
rd_a6_zero 600 00

// ==== spi_cmd_top.f ====
spi_pkg.sv
spi_sclk_gen.sv
spi_shifter.sv
spi_cmd_ctrl.sv
spi_cmd_top.sv
spi_slave_model.sv
tb_spi_cmd_top.sv

// ==== Bender.yml ====
package:
  name: spi_cmd

sources:
  - spi_pkg.sv
  - spi_sclk_gen.sv
  - spi_shifter.sv
  - spi_cmd_ctrl.sv
  - spi_cmd_top.sv
  - target: simulation
    files:
      - spi_slave_model.sv
      - tb_spi_cmd_top.sv
